/* dcache_bus_pkg.sv */
/*
  Bus interface definitions for the data cache hit stage
  Word, byte-lane and address widths plus the bus commands
*/
package dcache_bus_pkg;

  // Data word width, fixed by the RISC-V data path
  localparam int xlen = 32;

  // Byte lanes per word
  localparam int xbytes = xlen / 8;

  // Physical address width
  localparam int plen = 32;

  // Commands towards the bus interface
  typedef enum logic [1:0]
  {
    biu_nop      = 2'd0,
    biu_readway  = 2'd1,
    biu_writeway = 2'd2
  } biu_cmd_e;

endpackage

/* dcache_ctrl_pkg.sv */
/*
  Control definitions for the data cache hit stage
  Memory-interface states and acknowledge sources
*/
package dcache_ctrl_pkg;

  // Memory-interface state machine
  typedef enum logic [2:0]
  {
    st_armed        = 3'd0,
    st_noncacheable = 3'd1,
    st_evict        = 3'd2,
    st_wait_fill    = 3'd3,
    st_recover      = 3'd4
  } mem_state_e;

  // Source the registered acknowledge follows
  typedef enum logic [1:0]
  {
    ack_none          = 2'd0,
    ack_hit           = 2'd1,
    ack_biu_cacheable = 2'd2,
    ack_noncacheable  = 2'd3
  } ack_src_e;

endpackage

/* dcache_mem_fsm.sv */
/*
  Memory-interface state machine of the data cache hit stage
  Issues fill and write-back commands, drives stall and acknowledge
*/
`timescale 1ns/100ps

module dcache_mem_fsm #(
  parameter int  INFLIGHT_DEPTH = 2,
  localparam int INFLIGHT_BITS  = $clog2(INFLIGHT_DEPTH + 1)
)
(
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic                       req_i,
  input  logic                       flush_i,
  input  logic                       is_cacheable_i,
  input  logic                       cache_hit_i,
  input  logic                       way_dirty_i,

  input  logic                       biucmd_ack_i,
  input  logic                       biucmd_noncacheable_ack_i,
  input  logic [INFLIGHT_BITS-1:0]   inflight_cnt_i,
  input  logic                       biu_ack_i,
  input  logic                       biu_stb_ack_i,
  input  logic                       biu_err_i,
  input  logic                       adr_match_i,

  output dcache_ctrl_pkg::mem_state_e state_o,
  output dcache_bus_pkg::biu_cmd_e   biucmd_o,
  output logic                       biucmd_noncacheable_req_o,
  output logic                       armed_o,
  output logic                       filling_o,
  output logic                       stall_o,
  output logic                       ack_o,
  output logic                       err_o
);

  import dcache_bus_pkg::*;
  import dcache_ctrl_pkg::*;

  logic     cache_ack;
  logic     biu_cacheable_ack;
  ack_src_e ack_src;

  // Hit on a live request
  assign cache_ack = req_i & is_cacheable_i & cache_hit_i & ~flush_i;

  // Requested word returned by the fill, or a hit meanwhile
  assign biu_cacheable_ack = (req_i & biu_ack_i & adr_match_i & ~flush_i) | cache_ack;

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_o   <= st_armed;
      armed_o   <= 1'b1;
      filling_o <= 1'b0;
      biucmd_o  <= biu_nop;
    end
    else
    begin
      case (state_o)
        st_armed:
        begin
          if (req_i && !is_cacheable_i && !flush_i)
          begin
            state_o <= st_noncacheable;
            armed_o <= 1'b0;
          end
          else if (req_i && is_cacheable_i && !cache_hit_i && !flush_i)
          begin
            // Fill first, a dirty victim goes out after the fill
            state_o   <= way_dirty_i ? st_evict : st_wait_fill;
            biucmd_o  <= biu_readway;
            armed_o   <= 1'b0;
            filling_o <= 1'b1;
          end
          else
          begin
            biucmd_o <= biu_nop;
          end
        end

        st_noncacheable:
        begin
          // Pipe flushed, last transfer done, or cacheable request after transfer
          if (flush_i ||
              (!req_i && inflight_cnt_i == INFLIGHT_BITS'(1) && biu_ack_i) ||
              (req_i && is_cacheable_i && biu_ack_i))
          begin
            state_o <= st_armed;
            armed_o <= 1'b1;
          end
        end

        st_evict,
        st_wait_fill:
        begin
          if (biucmd_ack_i || biu_err_i)
          begin
            state_o   <= st_recover;
            // Write back the captured victim
            biucmd_o  <= (state_o == st_evict) ? biu_writeway : biu_nop;
            filling_o <= 1'b0;
          end
        end

        st_recover:
        begin
          // Tag and data memories read again after the fill
          state_o  <= st_armed;
          biucmd_o <= biu_nop;
          armed_o  <= 1'b1;
        end

        default:
        begin
          state_o <= st_armed;
          armed_o <= 1'b1;
        end
      endcase
    end
  end

  // Non-cacheable request only while armed
  assign biucmd_noncacheable_req_o = (state_o == st_armed) & req_i & ~is_cacheable_i & ~flush_i;

  ////////////////////////////////////////
  // Stall and acknowledge
  ////////////////////////////////////////

  always_comb
  begin
    case (state_o)
      st_armed:
        stall_o = req_i & (is_cacheable_i ? ~cache_hit_i : ~biu_stb_ack_i);
      // Idle core waits for in-flight transfers to drain
      st_noncacheable:
        stall_o = ~req_i ? |inflight_cnt_i
                         : (is_cacheable_i ? ~biu_ack_i : ~biu_stb_ack_i);
      st_evict,
      st_wait_fill:
        stall_o = ~(biu_cacheable_ack | (req_i & cache_hit_i));
      st_recover:
        stall_o = ~(req_i & cache_hit_i);
      default:
        stall_o = 1'b0;
    endcase
  end

  // Acknowledge source per state
  always_comb
  begin
    case (state_o)
      st_armed,
      st_recover:      ack_src = ack_hit;
      st_noncacheable: ack_src = ack_noncacheable;
      st_evict,
      st_wait_fill:    ack_src = ack_biu_cacheable;
      default:         ack_src = ack_none;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ack_o <= 1'b0;
    end
    else
    begin
      case (ack_src)
        ack_hit:           ack_o <= cache_ack;
        ack_biu_cacheable: ack_o <= biu_cacheable_ack;
        ack_noncacheable:  ack_o <= biucmd_noncacheable_ack_i;
        default:           ack_o <= 1'b0;
      endcase
    end
  end

  // Bus error one cycle later
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      err_o <= 1'b0;
    end
    else
    begin
      err_o <= biu_err_i;
    end
  end

endmodule

/* dcache_read_path.sv */
/*
  Read path of the data cache hit stage
  Address decode, word select and registered read data
*/
`timescale 1ns/100ps

module dcache_read_path #(
  parameter int  IDX_BITS      = 4,
  parameter int  BLK_WORDS     = 4,
  localparam int OFFS_BITS     = $clog2(BLK_WORDS),
  localparam int BYTE_BITS     = $clog2(dcache_bus_pkg::xbytes),
  localparam int BLK_OFFS_BITS = OFFS_BITS + BYTE_BITS,
  localparam int TAG_BITS      = dcache_bus_pkg::plen - IDX_BITS - BLK_OFFS_BITS,
  localparam int LINE_BITS     = BLK_WORDS * dcache_bus_pkg::xlen
)
(
  input  logic                              clk_i,
  input  logic [dcache_bus_pkg::plen-1:0]   adr_i,
  input  logic                              is_cacheable_i,
  input  logic                              cache_hit_i,
  input  logic [LINE_BITS-1:0]              cache_line_i,
  input  logic                              in_biubuffer_i,
  input  logic [LINE_BITS-1:0]              biubuffer_i,
  input  logic [dcache_bus_pkg::xlen-1:0]   biu_q_i,
  input  logic [dcache_bus_pkg::plen-1:0]   biu_adro_i,
  input  dcache_ctrl_pkg::mem_state_e       state_i,

  output logic [IDX_BITS-1:0]               idx_o,
  output logic [TAG_BITS-1:0]               core_tag_o,
  output logic [OFFS_BITS-1:0]              offs_o,
  output logic [dcache_bus_pkg::xlen-1:0]   q_o,
  output logic                              adr_match_o
);

  import dcache_bus_pkg::*;
  import dcache_ctrl_pkg::*;

  logic [LINE_BITS-1:0] line_src;
  logic [xlen-1:0]      cache_q;

  // Address split, tag above index above word offset
  assign idx_o      = adr_i[BLK_OFFS_BITS +: IDX_BITS];
  assign core_tag_o = adr_i[plen-1 -: TAG_BITS];
  assign offs_o     = adr_i[BYTE_BITS +: OFFS_BITS];

  // Bus return for the same word
  assign adr_match_o = (biu_adro_i[plen-1:BYTE_BITS] == adr_i[plen-1:BYTE_BITS]);

  // Line still in the bus buffer takes priority
  assign line_src = in_biubuffer_i ? biubuffer_i : cache_line_i;
  assign cache_q  = line_src[offs_o * xlen +: xlen];

  // During either fill wait the hit decides the source
  always_ff @(posedge clk_i)
  begin
    if (state_i == st_wait_fill || state_i == st_evict)
    begin
      q_o <= cache_hit_i ? cache_q : biu_q_i;
    end
    else
    begin
      q_o <= is_cacheable_i ? cache_q : biu_q_i;
    end
  end

endmodule

/* dcache_write_buffer.sv */
/*
  Write buffer capture of the data cache hit stage
*/
`timescale 1ns/100ps

module dcache_write_buffer #(
  parameter int  WAYS      = 2,
  parameter int  IDX_BITS  = 4,
  parameter int  BLK_WORDS = 4,
  localparam int OFFS_BITS = $clog2(BLK_WORDS)
)
(
  input  logic                              clk_i,
  input  logic                              rst_ni,

  input  logic                              wreq_i,
  input  logic                              flush_i,
  input  logic                              is_cacheable_i,
  input  logic                              cache_hit_i,
  input  logic [IDX_BITS-1:0]               idx_i,
  input  logic [OFFS_BITS-1:0]              offs_i,
  input  logic [dcache_bus_pkg::xlen-1:0]   d_i,
  input  logic [dcache_bus_pkg::xbytes-1:0] be_i,
  input  logic [WAYS-1:0]                   ways_hit_i,
  input  logic                              writebuffer_ack_i,

  output logic                              writebuffer_we_o,
  output logic [IDX_BITS-1:0]               writebuffer_idx_o,
  output logic [OFFS_BITS-1:0]              writebuffer_offs_o,
  output logic [dcache_bus_pkg::xlen-1:0]   writebuffer_data_o,
  output logic [dcache_bus_pkg::xbytes-1:0] writebuffer_be_o,
  output logic [WAYS-1:0]                   writebuffer_ways_hit_o
);

  logic capture;

  // Cacheable write hit, not cancelled
  assign capture = wreq_i & is_cacheable_i & cache_hit_i & ~flush_i;

  // Request held until acknowledged
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      writebuffer_we_o <= 1'b0;
    end
    else if (flush_i)
    begin
      writebuffer_we_o <= 1'b0;
    end
    else if (capture)
    begin
      writebuffer_we_o <= 1'b1;
    end
    else if (writebuffer_ack_i)
    begin
      writebuffer_we_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (capture)
    begin
      writebuffer_idx_o      <= idx_i;
      writebuffer_offs_o     <= offs_i;
      writebuffer_data_o     <= d_i;
      writebuffer_be_o       <= be_i;
      writebuffer_ways_hit_o <= ways_hit_i;
    end
  end

endmodule

/* dcache_evict_buffer.sv */
/*
  Evict buffer of the data cache hit stage
  Holds the victim address and line across a miss
*/
`timescale 1ns/100ps

module dcache_evict_buffer #(
  parameter int  IDX_BITS      = 4,
  parameter int  BLK_WORDS     = 4,
  localparam int BLK_OFFS_BITS = $clog2(BLK_WORDS) + $clog2(dcache_bus_pkg::xbytes),
  localparam int TAG_BITS      = dcache_bus_pkg::plen - IDX_BITS - BLK_OFFS_BITS,
  localparam int LINE_BITS     = BLK_WORDS * dcache_bus_pkg::xlen
)
(
  input  logic                            clk_i,
  input  dcache_ctrl_pkg::mem_state_e     state_i,
  input  logic [TAG_BITS-1:0]             evict_tag_i,
  input  logic [IDX_BITS-1:0]             idx_i,
  input  logic [LINE_BITS-1:0]            evict_line_i,

  output logic [dcache_bus_pkg::plen-1:0] evictbuffer_adr_o,
  output logic [LINE_BITS-1:0]            evictbuffer_line_o
);

  import dcache_ctrl_pkg::*;

  // Tracks the victim while armed, frozen once a miss starts
  always_ff @(posedge clk_i)
  begin
    if (state_i == st_armed)
    begin
      evictbuffer_adr_o  <= {evict_tag_i, idx_i, {BLK_OFFS_BITS{1'b0}}};
      evictbuffer_line_o <= evict_line_i;
    end
  end

endmodule

/* dcache_hit.sv */
/*
  Data cache hit stage
  Serves hits, queues writes, starts fills and write-backs
*/
`timescale 1ns/100ps

module dcache_hit #(
  parameter int  WAYS           = 2,
  parameter int  IDX_BITS       = 4,
  parameter int  BLK_WORDS      = 4,
  parameter int  INFLIGHT_DEPTH = 2,
  localparam int OFFS_BITS      = $clog2(BLK_WORDS),
  localparam int TAG_BITS       = dcache_bus_pkg::plen - IDX_BITS - OFFS_BITS -
                                  $clog2(dcache_bus_pkg::xbytes),
  localparam int LINE_BITS      = BLK_WORDS * dcache_bus_pkg::xlen,
  localparam int INFLIGHT_BITS  = $clog2(INFLIGHT_DEPTH + 1)
)
(
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // Core side
  input  logic                              req_i,
  input  logic                              wreq_i,
  input  logic [dcache_bus_pkg::plen-1:0]   adr_i,
  input  logic [dcache_bus_pkg::xlen-1:0]   d_i,
  input  logic [dcache_bus_pkg::xbytes-1:0] be_i,
  input  logic                              is_cacheable_i,
  input  logic                              flush_i,
  output logic                              stall_o,
  output logic                              ack_o,
  output logic [dcache_bus_pkg::xlen-1:0]   q_o,
  output logic                              err_o,
  output logic                              armed_o,
  output logic                              filling_o,

  // Cache memories
  input  logic                              cache_hit_i,
  input  logic [WAYS-1:0]                   ways_hit_i,
  input  logic [LINE_BITS-1:0]              cache_line_i,
  input  logic                              way_dirty_i,
  input  logic [TAG_BITS-1:0]               evict_tag_i,
  input  logic [LINE_BITS-1:0]              evict_line_i,
  output logic [IDX_BITS-1:0]               idx_o,
  output logic [TAG_BITS-1:0]               core_tag_o,

  // Write buffer
  output logic                              writebuffer_we_o,
  input  logic                              writebuffer_ack_i,
  output logic [IDX_BITS-1:0]               writebuffer_idx_o,
  output logic [OFFS_BITS-1:0]              writebuffer_offs_o,
  output logic [dcache_bus_pkg::xlen-1:0]   writebuffer_data_o,
  output logic [dcache_bus_pkg::xbytes-1:0] writebuffer_be_o,
  output logic [WAYS-1:0]                   writebuffer_ways_hit_o,

  // Evict buffer
  output logic [dcache_bus_pkg::plen-1:0]   evictbuffer_adr_o,
  output logic [LINE_BITS-1:0]              evictbuffer_line_o,

  // Bus interface
  output dcache_bus_pkg::biu_cmd_e          biucmd_o,
  input  logic                              biucmd_ack_i,
  output logic                              biucmd_noncacheable_req_o,
  input  logic                              biucmd_noncacheable_ack_i,
  input  logic [INFLIGHT_BITS-1:0]          inflight_cnt_i,
  input  logic [dcache_bus_pkg::xlen-1:0]   biu_q_i,
  input  logic                              biu_ack_i,
  input  logic                              biu_stb_ack_i,
  input  logic                              biu_err_i,
  input  logic [dcache_bus_pkg::plen-1:0]   biu_adro_i,
  input  logic                              in_biubuffer_i,
  input  logic [LINE_BITS-1:0]              biubuffer_i
);

  import dcache_ctrl_pkg::*;

  mem_state_e           state;
  logic [OFFS_BITS-1:0] offs;
  logic                 adr_match;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  dcache_mem_fsm #(
    .INFLIGHT_DEPTH (INFLIGHT_DEPTH)
  ) u_mem_fsm (
    .clk_i                     (clk_i),
    .rst_ni                    (rst_ni),
    .req_i                     (req_i),
    .flush_i                   (flush_i),
    .is_cacheable_i            (is_cacheable_i),
    .cache_hit_i               (cache_hit_i),
    .way_dirty_i               (way_dirty_i),
    .biucmd_ack_i              (biucmd_ack_i),
    .biucmd_noncacheable_ack_i (biucmd_noncacheable_ack_i),
    .inflight_cnt_i            (inflight_cnt_i),
    .biu_ack_i                 (biu_ack_i),
    .biu_stb_ack_i             (biu_stb_ack_i),
    .biu_err_i                 (biu_err_i),
    .adr_match_i               (adr_match),
    .state_o                   (state),
    .biucmd_o                  (biucmd_o),
    .biucmd_noncacheable_req_o (biucmd_noncacheable_req_o),
    .armed_o                   (armed_o),
    .filling_o                 (filling_o),
    .stall_o                   (stall_o),
    .ack_o                     (ack_o),
    .err_o                     (err_o)
  );

  ////////////////////////////////////////
  // Data paths
  ////////////////////////////////////////

  dcache_read_path #(
    .IDX_BITS  (IDX_BITS),
    .BLK_WORDS (BLK_WORDS)
  ) u_read_path (
    .clk_i          (clk_i),
    .adr_i          (adr_i),
    .is_cacheable_i (is_cacheable_i),
    .cache_hit_i    (cache_hit_i),
    .cache_line_i   (cache_line_i),
    .in_biubuffer_i (in_biubuffer_i),
    .biubuffer_i    (biubuffer_i),
    .biu_q_i        (biu_q_i),
    .biu_adro_i     (biu_adro_i),
    .state_i        (state),
    .idx_o          (idx_o),
    .core_tag_o     (core_tag_o),
    .offs_o         (offs),
    .q_o            (q_o),
    .adr_match_o    (adr_match)
  );

  // Write hits queued towards the data memory
  dcache_write_buffer #(
    .WAYS      (WAYS),
    .IDX_BITS  (IDX_BITS),
    .BLK_WORDS (BLK_WORDS)
  ) u_write_buffer (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .wreq_i                 (wreq_i),
    .flush_i                (flush_i),
    .is_cacheable_i         (is_cacheable_i),
    .cache_hit_i            (cache_hit_i),
    .idx_i                  (idx_o),
    .offs_i                 (offs),
    .d_i                    (d_i),
    .be_i                   (be_i),
    .ways_hit_i             (ways_hit_i),
    .writebuffer_ack_i      (writebuffer_ack_i),
    .writebuffer_we_o       (writebuffer_we_o),
    .writebuffer_idx_o      (writebuffer_idx_o),
    .writebuffer_offs_o     (writebuffer_offs_o),
    .writebuffer_data_o     (writebuffer_data_o),
    .writebuffer_be_o       (writebuffer_be_o),
    .writebuffer_ways_hit_o (writebuffer_ways_hit_o)
  );

  dcache_evict_buffer #(
    .IDX_BITS  (IDX_BITS),
    .BLK_WORDS (BLK_WORDS)
  ) u_evict_buffer (
    .clk_i              (clk_i),
    .state_i            (state),
    .evict_tag_i        (evict_tag_i),
    .idx_i              (idx_o),
    .evict_line_i       (evict_line_i),
    .evictbuffer_adr_o  (evictbuffer_adr_o),
    .evictbuffer_line_o (evictbuffer_line_o)
  );

endmodule

/* tb_dcache_hit.sv */
/*
  Self-checking testbench for the data cache hit stage
  Models the memory side and checks hits, misses and bus accesses
*/
`timescale 1ns/100ps

module tb_dcache_hit;

  import dcache_bus_pkg::*;

  localparam int LINE_W  = 128;
  localparam int TAG_W   = 24;
  localparam int ROUNDS  = 8;
  localparam int TESTS   = 7;
  localparam int LIMIT   = 40 * ROUNDS * TESTS + 16;

  logic              clk_i;
  logic              rst_ni;
  logic              req_i;
  logic              wreq_i;
  logic [plen-1:0]   adr_i;
  logic [xlen-1:0]   d_i;
  logic [xbytes-1:0] be_i;
  logic              is_cacheable_i;
  logic              flush_i;
  logic              stall_o;
  logic              ack_o;
  logic [xlen-1:0]   q_o;
  logic              err_o;
  logic              armed_o;
  logic              filling_o;
  logic              cache_hit_i;
  logic [1:0]        ways_hit_i;
  logic [LINE_W-1:0] cache_line_i;
  logic              way_dirty_i;
  logic [TAG_W-1:0]  evict_tag_i;
  logic [LINE_W-1:0] evict_line_i;
  logic [3:0]        idx_o;
  logic [TAG_W-1:0]  core_tag_o;
  logic              writebuffer_we_o;
  logic              writebuffer_ack_i;
  logic [3:0]        writebuffer_idx_o;
  logic [1:0]        writebuffer_offs_o;
  logic [xlen-1:0]   writebuffer_data_o;
  logic [xbytes-1:0] writebuffer_be_o;
  logic [1:0]        writebuffer_ways_hit_o;
  logic [plen-1:0]   evictbuffer_adr_o;
  logic [LINE_W-1:0] evictbuffer_line_o;
  biu_cmd_e          biucmd_o;
  logic              biucmd_ack_i;
  logic              biucmd_noncacheable_req_o;
  logic              biucmd_noncacheable_ack_i;
  logic [1:0]        inflight_cnt_i;
  logic [xlen-1:0]   biu_q_i;
  logic              biu_ack_i;
  logic              biu_stb_ack_i;
  logic              biu_err_i;
  logic [plen-1:0]   biu_adro_i;
  logic              in_biubuffer_i;
  logic [LINE_W-1:0] biubuffer_i;

  // Expected values, written by the stimulus process
  logic [xlen-1:0]   exp_q;
  logic [3:0]        exp_idx;
  logic [1:0]        exp_offs;
  logic [xlen-1:0]   exp_data;
  logic [xbytes-1:0] exp_be;
  logic [1:0]        exp_ways;
  logic [LINE_W-1:0] fill_line;
  logic [xlen-1:0]   nc_word;
  int                errors;
  int                cycles;

  dcache_hit u_dut (.*);

  ////////////////////////////////////////
  // Clock, timeout and helpers
  ////////////////////////////////////////

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial
  begin
    cycles = 0;
    while (cycles < LIMIT)
    begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", LIMIT);
    $display("Result: FAILED");
    $finish;
  end

  // Expected word: from the bus, or the addressed word of a line
  function automatic logic [xlen-1:0] ref_word(input logic [LINE_W-1:0] line,
                                              input logic [plen-1:0] adr,
                                              input logic from_bus,
                                              input logic [xlen-1:0] bus_q);
    logic [1:0] w;
    w = adr[3:2];
    if (from_bus)
      return bus_q;
    return line[w*xlen +: xlen];
  endfunction

  function automatic logic [LINE_W-1:0] rand_line();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic check_value(input logic [LINE_W-1:0] got, input logic [LINE_W-1:0] exp,
                             input string msg);
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %0t: %s got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  // Hold the request until the stage stops stalling
  task automatic wait_accept();
    do
      @(posedge clk_i);
    while (stall_o);
    req_i  <= 1'b0;
    wreq_i <= 1'b0;
  endtask

  task automatic wait_armed(output logic saw_writeway);
    saw_writeway = 1'b0;
    do
    begin
      @(negedge clk_i);
      if (biucmd_o == biu_writeway)
        saw_writeway = 1'b1;
    end
    while (!armed_o);
  endtask

  ////////////////////////////////////////
  // Memory-side model
  ////////////////////////////////////////

  initial
  begin
    int unsigned delay;
    biu_ack_i = 1'b0;
    biu_adro_i = '0;
    biu_q_i = '0;
    biucmd_ack_i = 1'b0;
    biu_stb_ack_i = 1'b0;
    biucmd_noncacheable_ack_i = 1'b0;
    inflight_cnt_i = '0;
    forever
    begin
      @(posedge clk_i);
      if (biucmd_o == biu_readway)
      begin
        delay = $urandom_range(1, 5);
        repeat (delay - 1) @(posedge clk_i);
        // Another word of the line first, it must not end the miss
        biu_ack_i  <= 1'b1;
        biu_adro_i <= adr_i ^ 32'h4;
        biu_q_i    <= ~ref_word(fill_line, adr_i, 1'b0, '0);
        @(posedge clk_i);
        // Requested word, then the command done
        biu_adro_i <= adr_i;
        biu_q_i    <= ref_word(fill_line, adr_i, 1'b0, '0);
        @(posedge clk_i);
        biu_ack_i    <= 1'b0;
        biucmd_ack_i <= 1'b1;
        @(posedge clk_i);
        biucmd_ack_i <= 1'b0;
      end
      else if (biucmd_noncacheable_req_o)
      begin
        delay = $urandom_range(1, 5);
        repeat (delay - 1) @(posedge clk_i);
        biu_stb_ack_i             <= 1'b1;
        biucmd_noncacheable_ack_i <= 1'b1;
        biu_ack_i                 <= 1'b1;
        biu_q_i                   <= nc_word;
        inflight_cnt_i            <= 2'd1;
        @(posedge clk_i);
        // Last in-flight transfer drains
        biu_stb_ack_i             <= 1'b0;
        biucmd_noncacheable_ack_i <= 1'b0;
        @(posedge clk_i);
        biu_ack_i      <= 1'b0;
        inflight_cnt_i <= 2'd0;
      end
    end
  end

  // Compare process for read data and write-buffer fields
  always @(negedge clk_i)
  begin
    if (ack_o)
      check_value(q_o, exp_q, "read data");
    if (writebuffer_we_o)
    begin
      check_value(writebuffer_idx_o, exp_idx, "write buffer index");
      check_value(writebuffer_offs_o, exp_offs, "write buffer offset");
      check_value(writebuffer_data_o, exp_data, "write buffer data");
      check_value(writebuffer_be_o, exp_be, "write buffer byte enables");
      check_value(writebuffer_ways_hit_o, exp_ways, "write buffer ways");
    end
  end

  ////////////////////////////////////////
  // Test tasks
  ////////////////////////////////////////

  task automatic read_hit(input logic use_bb);
    logic [plen-1:0]   a;
    logic [LINE_W-1:0] line;
    logic [LINE_W-1:0] bb;
    a = $urandom & 32'hffff_fffc;
    line = rand_line();
    bb = rand_line();
    @(posedge clk_i);
    exp_q = ref_word(use_bb ? bb : line, a, 1'b0, '0);
    req_i <= 1'b1;
    adr_i <= a;
    is_cacheable_i <= 1'b1;
    cache_hit_i <= 1'b1;
    cache_line_i <= line;
    biubuffer_i <= bb;
    in_biubuffer_i <= use_bb;
    @(negedge clk_i);
    check_value(stall_o, 1'b0, "read hit stall");
    check_value(idx_o, a[7:4], "set index");
    check_value(core_tag_o, a[31:8], "core tag");
    wait_accept();
    @(negedge clk_i);
    check_value(ack_o, 1'b1, "read hit ack");
  endtask

  task automatic write_hit();
    logic [plen-1:0]   a;
    logic [LINE_W-1:0] line;
    int                hold;
    a = $urandom & 32'hffff_fffc;
    line = rand_line();
    exp_idx = a[7:4];
    exp_offs = a[3:2];
    exp_data = $urandom;
    exp_be = $urandom_range(1, 15);
    exp_ways = $urandom_range(0, 1) ? 2'b01 : 2'b10;
    @(posedge clk_i);
    exp_q = ref_word(line, a, 1'b0, '0);
    req_i <= 1'b1;
    wreq_i <= 1'b1;
    adr_i <= a;
    d_i <= exp_data;
    be_i <= exp_be;
    ways_hit_i <= exp_ways;
    is_cacheable_i <= 1'b1;
    cache_hit_i <= 1'b1;
    cache_line_i <= line;
    in_biubuffer_i <= 1'b0;
    wait_accept();
    @(negedge clk_i);
    check_value(writebuffer_we_o, 1'b1, "write buffer request");
    // Back-pressure, fields checked every cycle
    hold = $urandom_range(0, 3);
    repeat (hold)
    begin
      @(negedge clk_i);
      check_value(writebuffer_we_o, 1'b1, "write buffer held");
    end
    @(posedge clk_i);
    writebuffer_ack_i <= 1'b1;
    @(posedge clk_i);
    writebuffer_ack_i <= 1'b0;
    @(negedge clk_i);
    check_value(writebuffer_we_o, 1'b0, "write buffer release");
  endtask

  task automatic miss(input logic dirty);
    logic [plen-1:0]   a;
    logic [TAG_W-1:0]  etag;
    logic [LINE_W-1:0] eline;
    logic              saw_wb;
    a = $urandom & 32'hffff_fffc;
    etag = $urandom;
    eline = rand_line();
    fill_line = rand_line();
    @(posedge clk_i);
    exp_q = ref_word(fill_line, a, 1'b0, '0);
    req_i <= 1'b1;
    adr_i <= a;
    is_cacheable_i <= 1'b1;
    cache_hit_i <= 1'b0;
    way_dirty_i <= dirty;
    evict_tag_i <= etag;
    evict_line_i <= eline;
    // Stale line in the memories, never the returned word
    cache_line_i <= rand_line();
    in_biubuffer_i <= 1'b0;
    @(posedge clk_i);
    // Victim inputs move on once the miss is taken
    evict_tag_i <= ~etag;
    evict_line_i <= ~eline;
    @(negedge clk_i);
    check_value(biucmd_o, biu_readway, "fill command");
    check_value(filling_o, 1'b1, "filling flag");
    check_value(evictbuffer_adr_o, {etag, a[7:4], 4'b0000}, "evict address");
    check_value(evictbuffer_line_o, eline, "evict line");
    wait_accept();
    @(negedge clk_i);
    check_value(ack_o, 1'b1, "miss ack");
    check_value(evictbuffer_adr_o, {etag, a[7:4], 4'b0000}, "evict address held");
    check_value(evictbuffer_line_o, eline, "evict line held");
    wait_armed(saw_wb);
    check_value(saw_wb, dirty, "write-back command");
  endtask

  task automatic noncacheable();
    logic [plen-1:0] a;
    logic            saw_wb;
    a = $urandom & 32'hffff_fffc;
    nc_word = $urandom;
    @(posedge clk_i);
    exp_q = ref_word('0, a, 1'b1, nc_word);
    req_i <= 1'b1;
    adr_i <= a;
    is_cacheable_i <= 1'b0;
    cache_hit_i <= 1'b0;
    @(negedge clk_i);
    check_value(biucmd_noncacheable_req_o, 1'b1, "non-cacheable request");
    wait_accept();
    @(negedge clk_i);
    check_value(ack_o, 1'b1, "non-cacheable ack");
    wait_armed(saw_wb);
    check_value(saw_wb, 1'b0, "no write-back after non-cacheable");
  endtask

  task automatic bus_error();
    @(posedge clk_i);
    biu_err_i <= 1'b1;
    @(posedge clk_i);
    biu_err_i <= 1'b0;
    @(negedge clk_i);
    check_value(err_o, 1'b1, "bus error");
    @(negedge clk_i);
    check_value(err_o, 1'b0, "bus error end");
  endtask

  // Flushed write hit and miss leave no request behind
  task automatic flush_cancel(input logic hit);
    @(posedge clk_i);
    req_i <= 1'b1;
    wreq_i <= hit;
    adr_i <= $urandom & 32'hffff_fffc;
    is_cacheable_i <= 1'b1;
    cache_hit_i <= hit;
    flush_i <= 1'b1;
    @(posedge clk_i);
    req_i <= 1'b0;
    wreq_i <= 1'b0;
    flush_i <= 1'b0;
    @(negedge clk_i);
    check_value(writebuffer_we_o, 1'b0, "flushed write request");
    check_value(biucmd_o, biu_nop, "flushed bus command");
    check_value(armed_o, 1'b1, "armed after flush");
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial
  begin
    errors = 0;
    void'($urandom(24777));
    rst_ni = 1'b0;
    req_i = 1'b0;
    wreq_i = 1'b0;
    adr_i = '0;
    d_i = '0;
    be_i = '0;
    is_cacheable_i = 1'b0;
    flush_i = 1'b0;
    cache_hit_i = 1'b0;
    ways_hit_i = '0;
    cache_line_i = '0;
    way_dirty_i = 1'b0;
    evict_tag_i = '0;
    evict_line_i = '0;
    writebuffer_ack_i = 1'b0;
    biu_err_i = 1'b0;
    in_biubuffer_i = 1'b0;
    biubuffer_i = '0;
    fill_line = '0;
    nc_word = '0;
    exp_q = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value({ack_o, err_o, writebuffer_we_o, filling_o}, 4'b0000, "reset outputs");
    check_value(biucmd_o, biu_nop, "reset command");
    check_value(armed_o, 1'b1, "reset armed");
    for (int r = 0; r < ROUNDS; r++)
    begin
      read_hit(r[0]);
      write_hit();
      miss(1'b0);
      miss(1'b1);
      noncacheable();
      bus_error();
      flush_cancel(r[0]);
    end
    repeat (2) @(posedge clk_i);
    $display("Checks done with %0d errors", errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* filelist.f */
dcache_bus_pkg.sv
dcache_ctrl_pkg.sv
dcache_mem_fsm.sv
dcache_read_path.sv
dcache_write_buffer.sv
dcache_evict_buffer.sv
dcache_hit.sv
tb_dcache_hit.sv
